/* list.f */
+incdir+include
src/usb_pkg.sv
src/xfer_pkg.sv
src/usb_timeout_timer.sv
src/axis_skid.sv
src/bulk_telemetry.sv
src/usb_transactor.sv
src/usb_protocol.sv
dv/tb_clock_gen.sv
dv/usb_protocol_tb.sv

/* Makefile */
TOP := usb_protocol_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* dv/usb_protocol_tb.sv */
`timescale 1ns/1ps
`include "usb_macros.svh"

module usb_protocol_tb;
  import usb_pkg::*;
  import xfer_pkg::*;

  localparam logic [6:0] DEV_ADDR = 7'h2a;
  localparam int HSK_WAIT = 40;
  localparam int STREAM_WAIT = 200;
  // Rough length of each test in cycles
  localparam int LEN_FILTER = 150;
  localparam int LEN_OUT = 150;
  localparam int LEN_IN = 120;
  localparam int LEN_TIMEOUT = 2 * `USB_TIMEOUT_CYCLES + 60;
  localparam int LEN_TELE = 150;
  localparam int WATCHDOG_CYCLES =
    4 * (16 + LEN_FILTER + LEN_OUT + LEN_IN + LEN_TIMEOUT + LEN_TELE);

  logic clock;
  logic reset;
  logic [6:0] usb_addr_i;
  logic tok_recv_i;
  tok_type_t tok_type_i;
  logic [6:0] tok_addr_i;
  logic [3:0] tok_endp_i;
  logic hsk_recv_i;
  hsk_type_t hsk_type_i;
  logic hsk_send_o;
  hsk_type_t hsk_type_o;
  logic hsk_sent_i;
  logic usb_rx_tvalid_i;
  logic usb_rx_tready_o;
  logic usb_rx_tlast_i;
  logic [7:0] usb_rx_tdata_i;
  logic usb_tx_tvalid_o;
  logic usb_tx_tready_i;
  logic usb_tx_tlast_o;
  logic [7:0] usb_tx_tdata_o;
  logic blk_out_ready_i;
  logic blk_in_ready_i;
  logic blk_out_tvalid_o;
  logic blk_out_tready_i;
  logic blk_out_tlast_o;
  logic [7:0] blk_out_tdata_o;
  logic blk_in_tvalid_i;
  logic blk_in_tready_o;
  logic blk_in_tlast_i;
  logic [7:0] blk_in_tdata_i;
  logic has_telemetry_o;
  logic timeout_o;

  hsk_type_t hsk_seen_q[$];
  tele_rec_t exp_rec_q[$];
  int errors = 0;
  int checks = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int test_start_errors = 0;
  int out_valid_seen = 0;
  int tx_valid_seen = 0;
  int rx_ready_seen = 0;
  int timeout_seen = 0;

  tb_clock_gen #(.RESET_CYCLES(16)) i_clock_gen (.clock_o(clock), .reset_o(reset));

  usb_protocol i_dut (.clock_i(clock), .reset_i(reset), .*);

  // Encoder model, acknowledges each handshake one cycle later
  initial begin
    hsk_sent_i = 1'b0;
    forever begin
      @(negedge clock);
      if (hsk_sent_i) begin
        hsk_sent_i = 1'b0;
      end else if (hsk_send_o) begin
        hsk_seen_q.push_back(hsk_type_o);
        hsk_sent_i = 1'b1;
      end
    end
  end

  // Activity counters for the checks that look for silence
  initial begin
    forever begin
      @(negedge clock);
      #1;
      if (blk_out_tvalid_o) out_valid_seen++;
      if (usb_tx_tvalid_o) tx_valid_seen++;
      if (usb_rx_tready_o) rx_ready_seen++;
      if (timeout_o) timeout_seen++;
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * 10);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("Some tests failed");
    $finish;
  end

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_hsk(input string name, input hsk_type_t got, input hsk_type_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_beat(input string name, input stream_beat_t got,
                            input stream_beat_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s: got 0x%03h, expected 0x%03h", name, got, exp);
    end
  endtask

  task automatic check_rec(input string name, input tele_rec_t got, input tele_rec_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s: got 0x%02h, expected 0x%02h", name, got, exp);
    end
  endtask

  function automatic tele_rec_t make_rec(input xfer_result_t res);
    tele_rec_t rec;
    rec.endp = `USB_BULK_EP;
    rec.rsvd = 2'b00;
    rec.result = res;
    return rec;
  endfunction

  task automatic random_bytes(input int n, output logic [7:0] bytes[$]);
    bytes.delete();
    repeat (n) bytes.push_back(8'($urandom));
  endtask

  task automatic send_token(input tok_type_t kind, input logic [6:0] addr,
                            input logic [3:0] endp);
    repeat (2) @(negedge clock);
    tok_recv_i = 1'b1;
    tok_type_i = kind;
    tok_addr_i = addr;
    tok_endp_i = endp;
    @(negedge clock);
    tok_recv_i = 1'b0;
  endtask

  task automatic send_host_ack();
    @(negedge clock);
    hsk_recv_i = 1'b1;
    hsk_type_i = HSK_ACK;
    @(negedge clock);
    hsk_recv_i = 1'b0;
  endtask

  task automatic expect_hsk(input hsk_type_t exp);
    int n;
    n = 0;
    while (hsk_seen_q.size() == 0 && n < HSK_WAIT) begin
      @(negedge clock);
      #1;
      n++;
    end
    if (hsk_seen_q.size() == 0) begin
      errors++;
      $display("No handshake from the device within %0d cycles", HSK_WAIT);
    end else begin
      check_hsk("hsk_type_o", hsk_seen_q.pop_front(), exp);
    end
  endtask

  // Source side, drives usb_rx or blk_in from a negedge
  task automatic push_packet(input bit on_rx, input logic [7:0] bytes[$]);
    int i;
    int guard;
    bit fire;
    i = 0;
    guard = 0;
    while (i < bytes.size() && guard < STREAM_WAIT) begin
      if (on_rx) begin
        usb_rx_tvalid_i = 1'b1;
        usb_rx_tdata_i = bytes[i];
        usb_rx_tlast_i = i == bytes.size() - 1;
      end else begin
        blk_in_tvalid_i = 1'b1;
        blk_in_tdata_i = bytes[i];
        blk_in_tlast_i = i == bytes.size() - 1;
      end
      #1;
      fire = on_rx ? usb_rx_tready_o : blk_in_tready_o;
      @(negedge clock);
      guard++;
      if (fire) i++;
    end
    usb_rx_tvalid_i = 1'b0;
    usb_rx_tlast_i = 1'b0;
    blk_in_tvalid_i = 1'b0;
    blk_in_tlast_i = 1'b0;
    if (i < bytes.size()) begin
      errors++;
      $display("Source stream stalled after %0d of %0d bytes", i, bytes.size());
    end
  endtask

  // Sink side with random back-pressure, stops after tlast
  task automatic pull_packet(input bit from_tx, output stream_beat_t beats[$]);
    int guard;
    bit done;
    logic valid;
    logic ready;
    stream_beat_t beat;
    beats.delete();
    guard = 0;
    done = 1'b0;
    while (!done && guard < STREAM_WAIT) begin
      @(negedge clock);
      ready = $urandom_range(3, 0) != 0;
      if (from_tx) usb_tx_tready_i = ready;
      else blk_out_tready_i = ready;
      #1;
      valid = from_tx ? usb_tx_tvalid_o : blk_out_tvalid_o;
      beat.last = from_tx ? usb_tx_tlast_o : blk_out_tlast_o;
      beat.data = from_tx ? usb_tx_tdata_o : blk_out_tdata_o;
      if (valid && ready) begin
        beats.push_back(beat);
        done = beat.last;
      end
      guard++;
    end
    @(negedge clock);
    usb_tx_tready_i = 1'b1;
    blk_out_tready_i = 1'b1;
    if (!done) begin
      errors++;
      $display("Packet end never arrived, %0d beats seen", beats.size());
    end
  endtask

  task automatic check_packet(input string name, input stream_beat_t got[$],
                              input logic [7:0] bytes[$]);
    int i;
    stream_beat_t exp;
    if (got.size() != bytes.size()) begin
      errors++;
      $display("%s carried %0d beats where %0d were sent", name, got.size(), bytes.size());
    end
    for (i = 0; i < got.size() && i < bytes.size(); i++) begin
      exp.last = i == bytes.size() - 1;
      exp.data = bytes[i];
      check_beat(name, got[i], exp);
    end
  endtask

  task automatic test_reset_and_filter();
    int base_out;
    int base_tx;
    int base_rx;
    check_bit("hsk_send_o", hsk_send_o, 1'b0);
    check_bit("usb_tx_tvalid_o", usb_tx_tvalid_o, 1'b0);
    check_bit("blk_out_tvalid_o", blk_out_tvalid_o, 1'b0);
    check_bit("usb_rx_tready_o", usb_rx_tready_o, 1'b0);
    check_bit("blk_in_tready_o", blk_in_tready_o, 1'b0);
    check_bit("timeout_o", timeout_o, 1'b0);
    check_bit("has_telemetry_o", has_telemetry_o, 1'b0);
    base_out = out_valid_seen;
    base_tx = tx_valid_seen;
    base_rx = rx_ready_seen;
    // A wrongly taken IN would answer NAK, a wrongly taken OUT opens usb_rx
    blk_in_ready_i = 1'b0;
    send_token(TOK_IN, DEV_ADDR ^ 7'h01, `USB_BULK_EP);
    send_token(TOK_OUT, DEV_ADDR + 7'd3, `USB_BULK_EP);
    send_token(TOK_IN, DEV_ADDR, 4'd3);
    send_token(TOK_OUT, DEV_ADDR, 4'd0);
    send_token(TOK_SETUP, DEV_ADDR, `USB_BULK_EP);
    repeat (100) @(negedge clock);
    if (hsk_seen_q.size() != 0 || out_valid_seen != base_out ||
        tx_valid_seen != base_tx || rx_ready_seen != base_rx) begin
      errors++;
      $display("A token for another address or endpoint got a response");
    end
  endtask

  task automatic test_bulk_out();
    logic [7:0] bytes[$];
    stream_beat_t got[$];
    int base_out;
    blk_out_ready_i = 1'b1;
    random_bytes(1 + $urandom_range(15, 0), bytes);
    send_token(TOK_OUT, DEV_ADDR, `USB_BULK_EP);
    fork
      push_packet(1'b1, bytes);
      pull_packet(1'b0, got);
    join
    check_packet("blk_out", got, bytes);
    expect_hsk(HSK_ACK);
    exp_rec_q.push_back(make_rec(RES_ACK));
    // Not ready, packet is dropped
    blk_out_ready_i = 1'b0;
    base_out = out_valid_seen;
    random_bytes(1 + $urandom_range(15, 0), bytes);
    send_token(TOK_OUT, DEV_ADDR, `USB_BULK_EP);
    push_packet(1'b1, bytes);
    expect_hsk(HSK_NAK);
    if (out_valid_seen != base_out) begin
      errors++;
      $display("Bytes reached blk_out while the device was sending NAK");
    end
    blk_out_ready_i = 1'b1;
    exp_rec_q.push_back(make_rec(RES_NAK));
  endtask

  task automatic test_bulk_in();
    logic [7:0] bytes[$];
    stream_beat_t got[$];
    int base_timeout;
    blk_in_ready_i = 1'b1;
    base_timeout = timeout_seen;
    random_bytes(1 + $urandom_range(15, 0), bytes);
    send_token(TOK_IN, DEV_ADDR, `USB_BULK_EP);
    fork
      push_packet(1'b0, bytes);
      pull_packet(1'b1, got);
    join
    check_packet("usb_tx", got, bytes);
    send_host_ack();
    exp_rec_q.push_back(make_rec(RES_ACK));
    blk_in_ready_i = 1'b0;
    send_token(TOK_IN, DEV_ADDR, `USB_BULK_EP);
    // NAK is raised one cycle after the token
    #1;
    check_bit("hsk_send_o", hsk_send_o, 1'b1);
    expect_hsk(HSK_NAK);
    exp_rec_q.push_back(make_rec(RES_NAK));
    if (timeout_seen != base_timeout) begin
      errors++;
      $display("timeout_o pulsed although the host answered with ACK");
    end
  endtask

  task automatic test_in_timeout();
    logic [7:0] bytes[$];
    stream_beat_t got[$];
    int base_timeout;
    blk_in_ready_i = 1'b1;
    random_bytes(1 + $urandom_range(7, 0), bytes);
    send_token(TOK_IN, DEV_ADDR, `USB_BULK_EP);
    fork
      push_packet(1'b0, bytes);
      pull_packet(1'b1, got);
    join
    check_packet("usb_tx", got, bytes);
    base_timeout = timeout_seen;
    repeat (2 * `USB_TIMEOUT_CYCLES) @(negedge clock);
    if (timeout_seen - base_timeout != 1) begin
      errors++;
      $display("timeout_o pulsed %0d times where one pulse was due", timeout_seen - base_timeout);
    end
    exp_rec_q.push_back(make_rec(RES_TIMEOUT));
  endtask

  task automatic test_telemetry();
    logic [7:0] bytes[$];
    stream_beat_t got[$];
    tele_rec_t rec;
    int base_out;
    int i;
    base_out = out_valid_seen;
    random_bytes(1 + $urandom_range(7, 0), bytes);
    send_token(TOK_OUT, DEV_ADDR, `USB_TELE_EP);
    push_packet(1'b1, bytes);
    expect_hsk(HSK_STALL);
    if (out_valid_seen != base_out) begin
      errors++;
      $display("Telemetry OUT data leaked to blk_out");
    end
    check_bit("has_telemetry_o", has_telemetry_o, 1'b1);
    send_token(TOK_IN, DEV_ADDR, `USB_TELE_EP);
    pull_packet(1'b1, got);
    if (got.size() != exp_rec_q.size()) begin
      errors++;
      $display("Telemetry returned %0d records where %0d were due", got.size(), exp_rec_q.size());
    end
    for (i = 0; i < got.size() && i < exp_rec_q.size(); i++) begin
      rec = got[i].data;
      check_rec("usb_tx_tdata_o", rec, exp_rec_q[i]);
      check_bit("usb_tx_tlast_o", got[i].last, i == exp_rec_q.size() - 1);
    end
    send_host_ack();
    @(negedge clock);
    #1;
    check_bit("has_telemetry_o", has_telemetry_o, 1'b0);
    send_token(TOK_IN, DEV_ADDR, `USB_TELE_EP);
    expect_hsk(HSK_NAK);
    exp_rec_q.delete();
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors != test_start_errors) tests_failed++;
    $display("test %-22s %s", name, (errors == test_start_errors) ? "ok" : "FAILED");
    test_start_errors = errors;
  endtask

  initial begin
    void'($urandom(32'hb53c_de6c));
    usb_addr_i = DEV_ADDR;
    tok_recv_i = 1'b0;
    tok_type_i = TOK_OUT;
    tok_addr_i = '0;
    tok_endp_i = '0;
    hsk_recv_i = 1'b0;
    hsk_type_i = HSK_ACK;
    usb_rx_tvalid_i = 1'b0;
    usb_rx_tlast_i = 1'b0;
    usb_rx_tdata_i = '0;
    usb_tx_tready_i = 1'b1;
    blk_out_ready_i = 1'b1;
    blk_in_ready_i = 1'b0;
    blk_out_tready_i = 1'b1;
    blk_in_tvalid_i = 1'b0;
    blk_in_tlast_i = 1'b0;
    blk_in_tdata_i = '0;
    wait (reset == 1'b0);
    @(negedge clock);
    #1;
    test_reset_and_filter();
    finish_test("reset_and_filter");
    test_bulk_out();
    finish_test("bulk_out");
    test_bulk_in();
    finish_test("bulk_in");
    test_in_timeout();
    finish_test("in_timeout");
    test_telemetry();
    finish_test("telemetry");
    $display("%0d tests run, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* dv/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int RESET_CYCLES = 16
) (
  output logic clock_o,
  output logic reset_o
);

  initial begin
    clock_o = 1'b0;
    forever #5 clock_o = ~clock_o;
  end

  // Release on a falling edge, clear of the DUT sampling edge
  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock_o);
    @(negedge clock_o);
    reset_o = 1'b0;
  end

endmodule

/* src/usb_protocol.sv */
`timescale 1ns/1ps

module usb_protocol (
  input  logic               clock_i,
  input  logic               reset_i,
  input  logic [6:0]         usb_addr_i,
  input  logic               tok_recv_i,
  input  usb_pkg::tok_type_t tok_type_i,
  input  logic [6:0]         tok_addr_i,
  input  logic [3:0]         tok_endp_i,
  input  logic               hsk_recv_i,
  input  usb_pkg::hsk_type_t hsk_type_i,
  output logic               hsk_send_o,
  output usb_pkg::hsk_type_t hsk_type_o,
  input  logic               hsk_sent_i,
  input  logic               usb_rx_tvalid_i,
  output logic               usb_rx_tready_o,
  input  logic               usb_rx_tlast_i,
  input  logic [7:0]         usb_rx_tdata_i,
  output logic               usb_tx_tvalid_o,
  input  logic               usb_tx_tready_i,
  output logic               usb_tx_tlast_o,
  output logic [7:0]         usb_tx_tdata_o,
  input  logic               blk_out_ready_i,
  input  logic               blk_in_ready_i,
  output logic               blk_out_tvalid_o,
  input  logic               blk_out_tready_i,
  output logic               blk_out_tlast_o,
  output logic [7:0]         blk_out_tdata_o,
  input  logic               blk_in_tvalid_i,
  output logic               blk_in_tready_o,
  input  logic               blk_in_tlast_i,
  input  logic [7:0]         blk_in_tdata_i,
  output logic               has_telemetry_o,
  output logic               timeout_o
);
  import usb_pkg::*;
  import xfer_pkg::*;

  logic         out_tvalid;
  logic         out_tready;
  logic         out_tlast;
  logic [7:0]   out_tdata;
  stream_beat_t out_beat;
  stream_beat_t blk_out_beat;
  logic         tele_sel;
  logic         tele_empty;
  logic         tele_tvalid;
  logic         tele_tlast;
  logic [7:0]   tele_tdata;
  logic         mux_tvalid;
  stream_beat_t mux_beat;
  logic         in_tready;
  logic         tx_accept;
  stream_beat_t tx_beat;
  logic         timer_start;
  logic         timer_stop;
  logic         timer_expired;
  logic         rec_write;
  tele_rec_t    rec;

  assign out_beat         = '{last: out_tlast, data: out_tdata};
  assign blk_out_tlast_o  = blk_out_beat.last;
  assign blk_out_tdata_o  = blk_out_beat.data;
  assign usb_tx_tlast_o   = tx_beat.last;
  assign usb_tx_tdata_o   = tx_beat.data;
  assign has_telemetry_o  = !tele_empty;
  assign timer_stop       = hsk_recv_i && hsk_type_i == HSK_ACK;

  // IN source mux, user stream or telemetry records
  always_comb begin
    if (tele_sel) begin
      mux_tvalid = tele_tvalid;
      mux_beat   = '{last: tele_tlast, data: tele_tdata};
    end else begin
      mux_tvalid = blk_in_tvalid_i;
      mux_beat   = '{last: blk_in_tlast_i, data: blk_in_tdata_i};
    end
  end

  assign blk_in_tready_o = in_tready && !tele_sel;

  usb_transactor i_transactor (
    .clock_i(clock_i), .reset_i(reset_i), .usb_addr_i(usb_addr_i),
    .tok_recv_i(tok_recv_i), .tok_type_i(tok_type_i),
    .tok_addr_i(tok_addr_i), .tok_endp_i(tok_endp_i),
    .hsk_recv_i(hsk_recv_i), .hsk_type_i(hsk_type_i),
    .hsk_send_o(hsk_send_o), .hsk_type_o(hsk_type_o), .hsk_sent_i(hsk_sent_i),
    .rx_tvalid_i(usb_rx_tvalid_i), .rx_tready_o(usb_rx_tready_o),
    .rx_tlast_i(usb_rx_tlast_i), .rx_tdata_i(usb_rx_tdata_i),
    .out_tvalid_o(out_tvalid), .out_tready_i(out_tready),
    .out_tlast_o(out_tlast), .out_tdata_o(out_tdata),
    .blk_out_ready_i(blk_out_ready_i), .blk_in_ready_i(blk_in_ready_i),
    .tele_sel_o(tele_sel), .tele_empty_i(tele_empty),
    .in_tvalid_i(mux_tvalid), .in_tready_o(in_tready), .in_tlast_i(mux_beat.last),
    .tx_beat_accept_i(tx_accept),
    .timer_start_o(timer_start), .timer_expired_i(timer_expired), .timeout_o(timeout_o),
    .rec_write_o(rec_write), .rec_o(rec)
  );

  usb_timeout_timer i_timer (
    .clock_i(clock_i), .reset_i(reset_i),
    .start_i(timer_start), .stop_i(timer_stop), .expired_o(timer_expired)
  );

  bulk_telemetry i_telemetry (
    .clock_i(clock_i), .reset_i(reset_i),
    .rec_write_i(rec_write), .rec_i(rec),
    .m_tvalid_o(tele_tvalid), .m_tready_i(in_tready && tele_sel),
    .m_tlast_o(tele_tlast), .m_tdata_o(tele_tdata), .empty_o(tele_empty)
  );

  // Source valid is gated by the transactor, so only TX_DATA beats enter
  axis_skid i_tx_skid (
    .clock_i(clock_i), .reset_i(reset_i),
    .s_tvalid_i(mux_tvalid && in_tready), .s_tready_o(tx_accept), .s_beat_i(mux_beat),
    .m_tvalid_o(usb_tx_tvalid_o), .m_tready_i(usb_tx_tready_i), .m_beat_o(tx_beat)
  );

  axis_skid i_out_skid (
    .clock_i(clock_i), .reset_i(reset_i),
    .s_tvalid_i(out_tvalid), .s_tready_o(out_tready), .s_beat_i(out_beat),
    .m_tvalid_o(blk_out_tvalid_o), .m_tready_i(blk_out_tready_i), .m_beat_o(blk_out_beat)
  );

endmodule

/* src/usb_transactor.sv */
`timescale 1ns/1ps
`include "usb_macros.svh"

module usb_transactor (
  input  logic                clock_i,
  input  logic                reset_i,
  input  logic [6:0]          usb_addr_i,
  input  logic                tok_recv_i,
  input  usb_pkg::tok_type_t  tok_type_i,
  input  logic [6:0]          tok_addr_i,
  input  logic [3:0]          tok_endp_i,
  input  logic                hsk_recv_i,
  input  usb_pkg::hsk_type_t  hsk_type_i,
  output logic                hsk_send_o,
  output usb_pkg::hsk_type_t  hsk_type_o,
  input  logic                hsk_sent_i,
  input  logic                rx_tvalid_i,
  output logic                rx_tready_o,
  input  logic                rx_tlast_i,
  input  logic [7:0]          rx_tdata_i,
  output logic                out_tvalid_o,
  input  logic                out_tready_i,
  output logic                out_tlast_o,
  output logic [7:0]          out_tdata_o,
  input  logic                blk_out_ready_i,
  input  logic                blk_in_ready_i,
  output logic                tele_sel_o,
  input  logic                tele_empty_i,
  input  logic                in_tvalid_i,
  output logic                in_tready_o,
  input  logic                in_tlast_i,
  input  logic                tx_beat_accept_i,
  output logic                timer_start_o,
  input  logic                timer_expired_i,
  output logic                timeout_o,
  output logic                rec_write_o,
  output xfer_pkg::tele_rec_t rec_o
);
  import usb_pkg::*;
  import xfer_pkg::*;

  xfer_state_t                  state_q;
  hsk_type_t                    hsk_type_q;
  logic                         hsk_send_q;
  logic                         tele_sel_q;
  logic [$clog2(`USB_MAX_PKT):0] in_count_q;
  stream_beat_t                 rx_beat;
  logic                         tok_tele;
  logic                         tok_hit;
  logic                         rx_fire;
  logic                         in_fire;
  logic                         host_ack;
  xfer_result_t                 rec_result;

  assign tok_tele = tok_endp_i == `USB_TELE_EP;
  assign tok_hit  = tok_recv_i && tok_addr_i == usb_addr_i &&
                    (tok_endp_i == `USB_BULK_EP || tok_tele);
  assign host_ack = hsk_recv_i && hsk_type_i == HSK_ACK;

  // OUT bytes only reach the user in RX_DATA; DRAIN swallows them
  assign rx_beat      = '{last: rx_tlast_i, data: rx_tdata_i};
  assign out_tvalid_o = rx_tvalid_i && state_q == ST_RX_DATA;
  assign out_tlast_o  = rx_beat.last;
  assign out_tdata_o  = rx_beat.data;
  assign rx_tready_o  = (state_q == ST_RX_DATA) ? out_tready_i : state_q == ST_DRAIN;
  assign rx_fire      = rx_tvalid_i && rx_tready_o;

  // IN source is opened only while sending and the tx skid has room
  assign in_tready_o   = state_q == ST_TX_DATA && tx_beat_accept_i;
  assign in_fire       = in_tvalid_i && in_tready_o;
  assign timer_start_o = in_fire && in_tlast_i;
  assign timeout_o     = state_q == ST_WAIT_HSK && timer_expired_i && !host_ack;

  assign hsk_send_o = hsk_send_q;
  assign hsk_type_o = hsk_type_q;
  assign tele_sel_o = tele_sel_q;

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      state_q    <= ST_IDLE;
      hsk_send_q <= 1'b0;
      hsk_type_q <= HSK_ACK;
      tele_sel_q <= 1'b0;
      in_count_q <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          in_count_q <= '0;
          if (tok_hit && tok_type_i == TOK_OUT) begin
            tele_sel_q <= tok_tele;
            if (tok_tele) begin
              state_q    <= ST_DRAIN;
              hsk_type_q <= HSK_STALL;
            end else if (blk_out_ready_i) begin
              state_q    <= ST_RX_DATA;
              hsk_type_q <= HSK_ACK;
            end else begin
              state_q    <= ST_DRAIN;
              hsk_type_q <= HSK_NAK;
            end
          end else if (tok_hit && tok_type_i == TOK_IN) begin
            tele_sel_q <= tok_tele;
            hsk_type_q <= HSK_NAK;
            // Nothing to send, so NAK straight away
            if (tok_tele ? tele_empty_i : !blk_in_ready_i) begin
              state_q    <= ST_SEND_HSK;
              hsk_send_q <= 1'b1;
            end else begin
              state_q <= ST_TX_DATA;
            end
          end
        end
        ST_RX_DATA, ST_DRAIN: begin
          if (rx_fire && rx_tlast_i) begin
            state_q    <= ST_SEND_HSK;
            hsk_send_q <= 1'b1;
          end
        end
        ST_TX_DATA: begin
          if (in_fire) begin
            in_count_q <= in_count_q + 1'b1;
          end
          if (in_fire && in_tlast_i) begin
            state_q <= ST_WAIT_HSK;
          end
        end
        ST_WAIT_HSK: begin
          if (host_ack || timer_expired_i) begin
            state_q <= ST_IDLE;
          end
        end
        ST_SEND_HSK: begin
          if (hsk_sent_i) begin
            state_q    <= ST_IDLE;
            hsk_send_q <= 1'b0;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Bulk transactions log their outcome as they finish
  always_comb begin
    rec_write_o = 1'b0;
    rec_result  = RES_ACK;
    if (!tele_sel_q) begin
      if (state_q == ST_SEND_HSK && hsk_sent_i) begin
        rec_write_o = 1'b1;
        case (hsk_type_q)
          HSK_NAK:   rec_result = RES_NAK;
          HSK_STALL: rec_result = RES_STALL;
          default:   rec_result = RES_ACK;
        endcase
      end else if (state_q == ST_WAIT_HSK && host_ack) begin
        rec_write_o = 1'b1;
      end else if (state_q == ST_WAIT_HSK && timer_expired_i) begin
        rec_write_o = 1'b1;
        rec_result  = RES_TIMEOUT;
      end
    end
  end

  assign rec_o = '{endp: `USB_BULK_EP, rsvd: 2'b00, result: rec_result};

  a_hsk_only_in_send: assert property (@(posedge clock_i) disable iff (reset_i)
    hsk_send_q |-> state_q == ST_SEND_HSK);

  // User packets must respect the bulk packet size
  a_in_pkt_len: assert property (@(posedge clock_i) disable iff (reset_i)
    in_fire && !tele_sel_q |-> in_count_q < `USB_MAX_PKT);

endmodule

/* src/bulk_telemetry.sv */
`timescale 1ns/1ps
`include "usb_macros.svh"

module bulk_telemetry (
  input  logic                clock_i,
  input  logic                reset_i,
  input  logic                rec_write_i,
  input  xfer_pkg::tele_rec_t rec_i,
  output logic                m_tvalid_o,
  input  logic                m_tready_i,
  output logic                m_tlast_o,
  output logic [7:0]          m_tdata_o,
  output logic                empty_o
);
  import xfer_pkg::*;

  localparam int AW = $clog2(`USB_TELE_DEPTH);
  localparam logic [AW:0] DEPTH = `USB_TELE_DEPTH;

  tele_rec_t     mem [`USB_TELE_DEPTH];
  logic [AW-1:0] wr_ptr_q;
  logic [AW-1:0] rd_ptr_q;
  logic [AW:0]   count_q;
  logic          full;
  logic          wr_en;
  logic          rd_en;

  assign full    = count_q == DEPTH;
  assign empty_o = count_q == '0;
  assign wr_en   = rec_write_i && !full;
  assign rd_en   = m_tvalid_o && m_tready_i;

  // Records go out as one byte each, last flag on the final one held
  assign m_tvalid_o = !empty_o;
  assign m_tdata_o  = mem[rd_ptr_q];
  assign m_tlast_o  = count_q == 1;

  always_ff @(posedge clock_i) begin
    if (wr_en) begin
      mem[wr_ptr_q] <= rec_i;
    end
  end

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // A record offered to a full FIFO leaves the write side untouched
  a_drop_when_full: assert property (@(posedge clock_i) disable iff (reset_i)
    rec_write_i && full |=> $stable(wr_ptr_q));

endmodule

/* src/axis_skid.sv */
`timescale 1ns/1ps

module axis_skid (
  input  logic                  clock_i,
  input  logic                  reset_i,
  input  logic                  s_tvalid_i,
  output logic                  s_tready_o,
  input  usb_pkg::stream_beat_t s_beat_i,
  output logic                  m_tvalid_o,
  input  logic                  m_tready_i,
  output usb_pkg::stream_beat_t m_beat_o
);
  import usb_pkg::*;

  stream_beat_t main_q;
  stream_beat_t skid_q;
  logic         main_valid_q;
  logic         skid_valid_q;
  logic         s_fire;
  logic         main_free;

  // Ready comes straight from a flop, so no path from m_tready_i
  assign s_tready_o = !skid_valid_q;
  assign m_tvalid_o = main_valid_q;
  assign m_beat_o   = main_q;
  assign s_fire     = s_tvalid_i && s_tready_o;
  assign main_free  = !main_valid_q || m_tready_i;

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      main_valid_q <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (main_free) begin
      main_valid_q <= skid_valid_q || s_fire;
      skid_valid_q <= 1'b0;
    end else if (s_fire) begin
      skid_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clock_i) begin
    if (main_free) begin
      main_q <= skid_valid_q ? skid_q : s_beat_i;
    end
    // Output is stalled, park the new beat
    if (s_fire && !main_free) begin
      skid_q <= s_beat_i;
    end
  end

  // With both slots full, the waiting source beat has to stay put
  a_no_beat_while_full: assert property (@(posedge clock_i) disable iff (reset_i)
    s_tvalid_i && main_valid_q && skid_valid_q |=> s_tvalid_i && $stable(s_beat_i));

endmodule

/* src/usb_timeout_timer.sv */
`timescale 1ns/1ps
`include "usb_macros.svh"

module usb_timeout_timer (
  input  logic clock_i,
  input  logic reset_i,
  input  logic start_i,
  input  logic stop_i,
  output logic expired_o
);
  localparam int CW = $clog2(`USB_TIMEOUT_CYCLES);
  localparam logic [CW-1:0] LOAD = CW'(`USB_TIMEOUT_CYCLES - 1);

  logic [CW-1:0] count_q;
  logic          running_q;
  logic          expired_q;

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      count_q   <= '0;
      running_q <= 1'b0;
      expired_q <= 1'b0;
    end else begin
      expired_q <= 1'b0;
      if (start_i) begin
        count_q   <= LOAD;
        running_q <= 1'b1;
      end else if (stop_i) begin
        running_q <= 1'b0;
      end else if (running_q) begin
        // Single pulse when the count runs out
        if (count_q == '0) begin
          running_q <= 1'b0;
          expired_q <= 1'b1;
        end else begin
          count_q <= count_q - 1'b1;
        end
      end
    end
  end

  assign expired_o = expired_q;

endmodule

/* src/xfer_pkg.sv */
package xfer_pkg;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_RX_DATA,
    ST_DRAIN,
    ST_TX_DATA,
    ST_WAIT_HSK,
    ST_SEND_HSK
  } xfer_state_t;

  typedef enum logic [1:0] {
    RES_ACK     = 2'd0,
    RES_NAK     = 2'd1,
    RES_STALL   = 2'd2,
    RES_TIMEOUT = 2'd3
  } xfer_result_t;

  // Endpoint in the upper nibble, outcome in the low bits
  typedef struct packed {
    logic [3:0]   endp;
    logic [1:0]   rsvd;
    xfer_result_t result;
  } tele_rec_t;

endpackage

/* src/usb_pkg.sv */
package usb_pkg;

  // Token kinds, coded as PID bits 3:2 from the packet decoder
  typedef enum logic [1:0] {
    TOK_OUT   = 2'b00,
    TOK_IN    = 2'b10,
    TOK_SETUP = 2'b11
  } tok_type_t;

  // Handshake kinds, same PID bit slice
  typedef enum logic [1:0] {
    HSK_ACK   = 2'b00,
    HSK_NAK   = 2'b10,
    HSK_STALL = 2'b11
  } hsk_type_t;

  // One packet byte with its end marker
  typedef struct packed {
    logic       last;
    logic [7:0] data;
  } stream_beat_t;

endpackage

/* include/usb_macros.svh */
`ifndef USB_MACROS_SVH
`define USB_MACROS_SVH

// Endpoint numbers served by this device
`define USB_BULK_EP 4'd1
`define USB_TELE_EP 4'd2

// Clock cycles to wait for the host handshake after an IN packet
`define USB_TIMEOUT_CYCLES 64

// Records held by the telemetry FIFO
`define USB_TELE_DEPTH 16

// Largest bulk IN packet, in bytes
`define USB_MAX_PKT 64

`endif
